//--- hw/ilk_rr_arbiter.sv
`timescale 1ns/100ps

module ilk_rr_arbiter (
	// only used to sample the assertion
	input logic clk,
	input logic [ilk_tx_pkg::NUM_CHANS-1:0] req,
	input logic [ilk_tx_pkg::NUM_CHANS-1:0] base,
	output logic [ilk_tx_pkg::NUM_CHANS-1:0] grant
);

	logic [2*ilk_tx_pkg::NUM_CHANS-1:0] req_dbl;
	logic [2*ilk_tx_pkg::NUM_CHANS-1:0] base_dbl;
	logic [2*ilk_tx_pkg::NUM_CHANS-1:0] grant_dbl;

	// two copies of the requests side by side, so the search can wrap
	// past the top channel into the second copy
	assign req_dbl = {req, req};
	assign base_dbl = {{ilk_tx_pkg::NUM_CHANS{1'b0}}, base};

	// subtracting the base borrows through every idle position up to the
	// first requester at or above it; that requester is the only bit
	// that is set in the request and cleared in the difference
	assign grant_dbl = req_dbl & ~(req_dbl - base_dbl);

	// fold the upper copy back onto the channel positions
	assign grant = grant_dbl[ilk_tx_pkg::NUM_CHANS-1:0]
		| grant_dbl[2*ilk_tx_pkg::NUM_CHANS-1:ilk_tx_pkg::NUM_CHANS];

	//////////////////////////////////////////////////////////////////////
	// checks

	// holds as long as the base stays one-hot
	a_grant_onehot: assert property (@(posedge clk) $onehot0(grant))
		else $error("arbiter grant is not one-hot: %b", grant);

endmodule

//--- hw/ilk_tx_arb_regs.sv
`timescale 1ns/100ps

module ilk_tx_arb_regs (
	input logic clk,
	input logic arst,

	// write side
	input logic cfg_wr,
	input ilk_tx_pkg::ilk_reg_addr_e cfg_addr,
	input logic [ilk_tx_pkg::REG_W-1:0] cfg_wdata,

	// combinational read-back
	input ilk_tx_pkg::ilk_reg_addr_e cfg_rd_addr,
	output logic [ilk_tx_pkg::REG_W-1:0] cfg_rdata,

	output ilk_tx_pkg::ilk_arb_cfg_t cfg,
	output logic cnt_clear,
	input logic [ilk_tx_pkg::CNT_W-1:0] word_cnt [ilk_tx_pkg::NUM_CHANS]
);

	// every channel starts disabled, identifiers start at the channel index
	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			cfg.chan_enables <= '0;
			for (int n = 0; n < ilk_tx_pkg::NUM_CHANS; n++) begin
				cfg.chan_id[n] <= 8'(n);
			end
			cnt_clear <= 1'b0;
		end else begin
			cnt_clear <= cfg_wr && (cfg_addr == ilk_tx_pkg::REG_CNT_CLEAR);
			if (cfg_wr) begin
				case (cfg_addr)
					ilk_tx_pkg::REG_ENABLES:
						cfg.chan_enables <= cfg_wdata[ilk_tx_pkg::NUM_CHANS-1:0];
					ilk_tx_pkg::REG_CHAN_ID0: cfg.chan_id[0] <= cfg_wdata[7:0];
					ilk_tx_pkg::REG_CHAN_ID1: cfg.chan_id[1] <= cfg_wdata[7:0];
					ilk_tx_pkg::REG_CHAN_ID2: cfg.chan_id[2] <= cfg_wdata[7:0];
					ilk_tx_pkg::REG_CHAN_ID3: cfg.chan_id[3] <= cfg_wdata[7:0];
					default: ;
				endcase
			end
		end
	end

	// unmapped addresses and the clear strobe read as zero
	always_comb begin
		cfg_rdata = '0;
		case (cfg_rd_addr)
			ilk_tx_pkg::REG_ENABLES: cfg_rdata[ilk_tx_pkg::NUM_CHANS-1:0] = cfg.chan_enables;
			ilk_tx_pkg::REG_CHAN_ID0: cfg_rdata[7:0] = cfg.chan_id[0];
			ilk_tx_pkg::REG_CHAN_ID1: cfg_rdata[7:0] = cfg.chan_id[1];
			ilk_tx_pkg::REG_CHAN_ID2: cfg_rdata[7:0] = cfg.chan_id[2];
			ilk_tx_pkg::REG_CHAN_ID3: cfg_rdata[7:0] = cfg.chan_id[3];
			ilk_tx_pkg::REG_CNT0: cfg_rdata = word_cnt[0];
			ilk_tx_pkg::REG_CNT1: cfg_rdata = word_cnt[1];
			ilk_tx_pkg::REG_CNT2: cfg_rdata = word_cnt[2];
			ilk_tx_pkg::REG_CNT3: cfg_rdata = word_cnt[3];
			default: cfg_rdata = '0;
		endcase
	end

endmodule

//--- hw/ilk_tx_arb_top.sv
`timescale 1ns/100ps

module ilk_tx_arb_top (
	input logic clk,
	input logic arst,

	// register port
	input logic cfg_wr,
	input ilk_tx_pkg::ilk_reg_addr_e cfg_addr,
	input logic [ilk_tx_pkg::REG_W-1:0] cfg_wdata,
	input ilk_tx_pkg::ilk_reg_addr_e cfg_rd_addr,
	output logic [ilk_tx_pkg::REG_W-1:0] cfg_rdata,

	// channel sources
	input ilk_tx_pkg::ilk_beat_t src_beat [ilk_tx_pkg::NUM_CHANS],
	input logic [ilk_tx_pkg::NUM_CHANS-1:0] src_valid,
	output logic [ilk_tx_pkg::NUM_CHANS-1:0] src_ready,

	// merged output
	output ilk_tx_pkg::ilk_out_beat_t out_beat,
	output logic out_valid,
	input logic out_ready
);

	ilk_tx_pkg::ilk_arb_cfg_t cfg;
	logic cnt_clear;
	logic [ilk_tx_pkg::CNT_W-1:0] word_cnt [ilk_tx_pkg::NUM_CHANS];

	ilk_tx_arb_regs u_regs (
		.clk(clk),
		.arst(arst),
		.cfg_wr(cfg_wr),
		.cfg_addr(cfg_addr),
		.cfg_wdata(cfg_wdata),
		.cfg_rd_addr(cfg_rd_addr),
		.cfg_rdata(cfg_rdata),
		.cfg(cfg),
		.cnt_clear(cnt_clear),
		.word_cnt(word_cnt)
	);

	// counts what the sources actually hand over
	ilk_tx_word_counter u_word_counter (
		.clk(clk),
		.arst(arst),
		.cnt_clear(cnt_clear),
		.src_beat(src_beat),
		.src_valid(src_valid),
		.src_ready(src_ready),
		.word_cnt(word_cnt)
	);

	ilk_tx_chan_arbiter u_chan_arbiter (
		.clk(clk),
		.arst(arst),
		.cfg(cfg),
		.src_beat(src_beat),
		.src_valid(src_valid),
		.src_ready(src_ready),
		.out_beat(out_beat),
		.out_valid(out_valid),
		.out_ready(out_ready)
	);

endmodule

//--- hw/ilk_tx_chan_arbiter.sv
`timescale 1ns/100ps

module ilk_tx_chan_arbiter (
	input logic clk,
	input logic arst,

	input ilk_tx_pkg::ilk_arb_cfg_t cfg,

	// channel sources
	input ilk_tx_pkg::ilk_beat_t src_beat [ilk_tx_pkg::NUM_CHANS],
	input logic [ilk_tx_pkg::NUM_CHANS-1:0] src_valid,
	output logic [ilk_tx_pkg::NUM_CHANS-1:0] src_ready,

	// merged output
	output ilk_tx_pkg::ilk_out_beat_t out_beat,
	output logic out_valid,
	input logic out_ready
);

	logic [ilk_tx_pkg::NUM_CHANS-1:0] qual_req;
	logic [ilk_tx_pkg::NUM_CHANS-1:0] base;
	logic [ilk_tx_pkg::NUM_CHANS-1:0] grant;
	logic [ilk_tx_pkg::NUM_CHANS-1:0] grant_w;
	logic [ilk_tx_pkg::CHAN_IDX_W-1:0] enc_grant;
	logic [ilk_tx_pkg::CHAN_IDX_W-1:0] enc_grant_w;
	logic [ilk_tx_pkg::LOG_DAT_WORDS-1:0] out_cnt;
	ilk_tx_pkg::ilk_out_beat_t out_hold;

	//////////////////////////////////////////////////////////////////////
	// request qualification

	// a channel only competes when it is enabled and offers at least one word
	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			qual_req <= '0;
		end else begin
			for (int n = 0; n < ilk_tx_pkg::NUM_CHANS; n++) begin
				qual_req[n] <= cfg.chan_enables[n] & src_valid[n]
					& (|src_beat[n].num_words);
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// rotating priority

	ilk_rr_arbiter u_rr_arbiter (
		.clk(clk),
		.req(qual_req),
		.base(base),
		.grant(grant_w)
	);

	always_comb begin
		enc_grant_w = '0;
		for (int n = 0; n < ilk_tx_pkg::NUM_CHANS; n++) begin
			if (grant_w[n]) begin
				enc_grant_w = enc_grant_w | n[ilk_tx_pkg::CHAN_IDX_W-1:0];
			end
		end
	end

	// everything here advances together with the output stage
	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			base <= {{(ilk_tx_pkg::NUM_CHANS-1){1'b0}}, 1'b1};
			grant <= '0;
			enc_grant <= '0;
		end else if (out_ready) begin
			base <= {base[ilk_tx_pkg::NUM_CHANS-2:0], base[ilk_tx_pkg::NUM_CHANS-1]};
			grant <= grant_w;
			enc_grant <= enc_grant_w;
		end
	end

	// the granted channel is offered a ready only while the output can move
	assign src_ready = grant & {ilk_tx_pkg::NUM_CHANS{out_ready}};

	//////////////////////////////////////////////////////////////////////
	// output stage

	// the count is loaded from exactly the transfer the source sees, so a
	// missing grant or a dropped valid leaves an empty beat behind
	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			out_cnt <= '0;
		end else if (out_ready) begin
			if (src_ready[enc_grant] & src_valid[enc_grant]) begin
				out_cnt <= src_beat[enc_grant].num_words;
			end else begin
				out_cnt <= '0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (out_ready) begin
			out_hold.beat <= src_beat[enc_grant];
			out_hold.chan <= cfg.chan_id[enc_grant];
		end
	end

	always_comb begin
		out_beat = out_hold;
		out_beat.beat.num_words = out_cnt;
	end

	assign out_valid = |out_cnt;

	//////////////////////////////////////////////////////////////////////
	// checks

	a_no_ready_when_disabled: assert property (@(posedge clk) disable iff (arst)
		(src_ready & ~cfg.chan_enables) == '0)
		else $error("src_ready %b raised for a disabled channel", src_ready);

	a_out_stable: assert property (@(posedge clk) disable iff (arst)
		out_valid && !out_ready |=> $stable(out_beat))
		else $error("out_beat changed while stalled");

endmodule

//--- hw/ilk_tx_pkg.sv
package ilk_tx_pkg;

	//////////////////////////////////////////////////////////////////////
	// sizes

	localparam int NUM_CHANS = 4;
	localparam int CHAN_IDX_W = $clog2(NUM_CHANS);
	localparam int DAT_WORDS = 4;

	// wide enough to hold 0 up to DAT_WORDS inclusive
	localparam int LOG_DAT_WORDS = 3;

	localparam int CNT_W = 32;
	localparam int REG_W = 32;

	//////////////////////////////////////////////////////////////////////
	// beats and configuration

	typedef struct packed {
		logic [LOG_DAT_WORDS-1:0] num_words;
		logic [64*DAT_WORDS-1:0] words;
		logic sop;
		logic [3:0] eopbits;
	} ilk_beat_t;

	typedef struct packed {
		ilk_beat_t beat;
		logic [7:0] chan;
	} ilk_out_beat_t;

	typedef struct packed {
		logic [NUM_CHANS-1:0] chan_enables;
		logic [NUM_CHANS-1:0][7:0] chan_id;
	} ilk_arb_cfg_t;

	// register map, addresses 5 and 6 are unused
	typedef enum logic [3:0] {
		REG_ENABLES = 4'd0,
		REG_CHAN_ID0 = 4'd1,
		REG_CHAN_ID1 = 4'd2,
		REG_CHAN_ID2 = 4'd3,
		REG_CHAN_ID3 = 4'd4,
		REG_CNT_CLEAR = 4'd7,
		REG_CNT0 = 4'd8,
		REG_CNT1 = 4'd9,
		REG_CNT2 = 4'd10,
		REG_CNT3 = 4'd11
	} ilk_reg_addr_e;

endpackage

//--- hw/ilk_tx_word_counter.sv
`timescale 1ns/100ps

module ilk_tx_word_counter (
	input logic clk,
	input logic arst,
	input logic cnt_clear,
	input ilk_tx_pkg::ilk_beat_t src_beat [ilk_tx_pkg::NUM_CHANS],
	input logic [ilk_tx_pkg::NUM_CHANS-1:0] src_valid,
	input logic [ilk_tx_pkg::NUM_CHANS-1:0] src_ready,
	output logic [ilk_tx_pkg::CNT_W-1:0] word_cnt [ilk_tx_pkg::NUM_CHANS]
);

	logic [ilk_tx_pkg::NUM_CHANS-1:0] xfer;
	logic [ilk_tx_pkg::CNT_W:0] cnt_sum [ilk_tx_pkg::NUM_CHANS];

	// same transfer rule the sources follow, empty beats do not count
	always_comb begin
		for (int n = 0; n < ilk_tx_pkg::NUM_CHANS; n++) begin
			xfer[n] = src_valid[n] & src_ready[n] & (|src_beat[n].num_words);
			cnt_sum[n] = {1'b0, word_cnt[n]}
				+ (ilk_tx_pkg::CNT_W+1)'(src_beat[n].num_words);
		end
	end

	// a clear wins over a transfer in the same cycle
	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			for (int n = 0; n < ilk_tx_pkg::NUM_CHANS; n++) begin
				word_cnt[n] <= '0;
			end
		end else begin
			for (int n = 0; n < ilk_tx_pkg::NUM_CHANS; n++) begin
				if (cnt_clear) begin
					word_cnt[n] <= '0;
				end else if (xfer[n]) begin
					// stick at all ones once the carry comes out
					word_cnt[n] <= cnt_sum[n][ilk_tx_pkg::CNT_W] ? '1
						: cnt_sum[n][ilk_tx_pkg::CNT_W-1:0];
				end
			end
		end
	end

	// the arbiter serves one channel per cycle
	a_single_xfer: assert property (@(posedge clk) disable iff (arst) $onehot0(xfer))
		else $error("transfers on several channels at once: %b", xfer);

endmodule

//--- ilk_tx_arb_top.f
hw/ilk_tx_pkg.sv
hw/ilk_rr_arbiter.sv
hw/ilk_tx_chan_arbiter.sv
hw/ilk_tx_arb_regs.sv
hw/ilk_tx_word_counter.sv
hw/ilk_tx_arb_top.sv
testbench/tb_ilk_tx_arb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the channel arbiter testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_ilk_tx_arb -f ilk_tx_arb_top.f \
	--Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "TEST FAILED" sim.log; then
	echo "simulation reported failure"
	exit 1
fi
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi
if ! grep -q "TEST PASSED" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
exit 0

//--- testbench/tb_ilk_tx_arb.sv
`timescale 1ns/100ps

module tb_ilk_tx_arb;

	logic clk;
	logic arst;
	logic cfg_wr;
	ilk_tx_pkg::ilk_reg_addr_e cfg_addr;
	logic [31:0] cfg_wdata;
	ilk_tx_pkg::ilk_reg_addr_e cfg_rd_addr;
	logic [31:0] cfg_rdata;
	ilk_tx_pkg::ilk_beat_t src_beat [ilk_tx_pkg::NUM_CHANS];
	logic src_vld [ilk_tx_pkg::NUM_CHANS];
	logic [ilk_tx_pkg::NUM_CHANS-1:0] src_valid;
	logic [ilk_tx_pkg::NUM_CHANS-1:0] src_ready;
	ilk_tx_pkg::ilk_out_beat_t out_beat;
	logic out_valid;
	logic out_ready;

	// beats per source in each phase
	int fair_beats = 24;
	int bp_beats = 40;
	int en_beats = 24;

	// reference state kept beside the DUT
	ilk_tx_pkg::ilk_beat_t exp_beats [$];
	logic [7:0] exp_ids [$];
	logic [7:0] hist [$];
	logic [ilk_tx_pkg::NUM_CHANS-1:0] en_model;
	logic [7:0] id_model [ilk_tx_pkg::NUM_CHANS];
	logic [31:0] cnt_model [ilk_tx_pkg::NUM_CHANS];
	logic fair_on;
	logic bp_on;
	logic stall_prev;
	ilk_tx_pkg::ilk_out_beat_t prev_beat;

	assign src_valid = {src_vld[3], src_vld[2], src_vld[1], src_vld[0]};

	ilk_tx_arb_top UUT (
		.clk(clk),
		.arst(arst),
		.cfg_wr(cfg_wr),
		.cfg_addr(cfg_addr),
		.cfg_wdata(cfg_wdata),
		.cfg_rd_addr(cfg_rd_addr),
		.cfg_rdata(cfg_rdata),
		.src_beat(src_beat),
		.src_valid(src_valid),
		.src_ready(src_ready),
		.out_beat(out_beat),
		.out_valid(out_valid),
		.out_ready(out_ready)
	);

	always #50 clk = ~clk;

	//////////////////////////////////////////////////////////////////////
	// reference and checking

	// an output beat is the transferred beat tagged with its channel id
	function automatic ilk_tx_pkg::ilk_out_beat_t expected_out(
			ilk_tx_pkg::ilk_beat_t b, logic [7:0] id);
		ilk_tx_pkg::ilk_out_beat_t o;
		o.beat = b;
		o.chan = id;
		return o;
	endfunction

	// wide enough for a whole output beat
	task automatic check_val(string name,
			logic [$bits(ilk_tx_pkg::ilk_out_beat_t)-1:0] expected,
			logic [$bits(ilk_tx_pkg::ilk_out_beat_t)-1:0] actual);
		if (expected !== actual) begin
			$display("** Error: %s expected %0h actual %0h", name, expected, actual);
			$display("*** TEST FAILED ***");
			$fatal(1);
		end
	endtask

	always @(posedge clk) begin
		ilk_tx_pkg::ilk_out_beat_t exp_o;
		int dup;
		if (!arst) begin
			// back-pressure holds the output and keeps every source waiting
			if (!out_ready) begin
				check_val("no source ready while stalled", 0, src_ready);
			end
			if (stall_prev) begin
				check_val("out_beat held while stalled", prev_beat, out_beat);
			end
			check_val("ready on a disabled channel", 0, src_ready & ~en_model);

			if (out_valid && out_ready) begin
				if (exp_beats.size() == 0) begin
					$display("an output beat appeared with no source transfer behind it");
					$display("*** TEST FAILED ***");
					$fatal(1);
				end
				exp_o = expected_out(exp_beats.pop_front(), exp_ids.pop_front());
				check_val("num_words", exp_o.beat.num_words, out_beat.beat.num_words);
				check_val("words", exp_o.beat.words, out_beat.beat.words);
				check_val("sop", exp_o.beat.sop, out_beat.beat.sop);
				check_val("eopbits", exp_o.beat.eopbits, out_beat.beat.eopbits);
				check_val("chan", exp_o.chan, out_beat.chan);
				if (fair_on) begin
					dup = 0;
					foreach (hist[i]) begin
						if (hist[i] == out_beat.chan) begin
							dup = 1;
						end
					end
					check_val("fairness window of four", 0, dup);
					hist.push_back(out_beat.chan);
					if (hist.size() > 3) begin
						void'(hist.pop_front());
					end
				end
			end

			for (int n = 0; n < ilk_tx_pkg::NUM_CHANS; n++) begin
				if (src_vld[n] && src_ready[n] && src_beat[n].num_words != 0) begin
					exp_beats.push_back(src_beat[n]);
					exp_ids.push_back(id_model[n]);
					cnt_model[n] = cnt_model[n] + 32'(src_beat[n].num_words);
				end
			end

			// register writes land on this same edge inside the DUT
			if (cfg_wr) begin
				case (cfg_addr)
					ilk_tx_pkg::REG_ENABLES: en_model = cfg_wdata[3:0];
					ilk_tx_pkg::REG_CHAN_ID0: id_model[0] = cfg_wdata[7:0];
					ilk_tx_pkg::REG_CHAN_ID1: id_model[1] = cfg_wdata[7:0];
					ilk_tx_pkg::REG_CHAN_ID2: id_model[2] = cfg_wdata[7:0];
					ilk_tx_pkg::REG_CHAN_ID3: id_model[3] = cfg_wdata[7:0];
					ilk_tx_pkg::REG_CNT_CLEAR: begin
						for (int n = 0; n < ilk_tx_pkg::NUM_CHANS; n++) begin
							cnt_model[n] = 0;
						end
					end
					default: ;
				endcase
			end
			stall_prev = !out_ready;
			prev_beat = out_beat;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// stimulus

	always @(posedge clk) begin
		#10;
		out_ready = bp_on ? 1'($urandom % 2) : 1'b1;
	end

	task automatic write_reg(ilk_tx_pkg::ilk_reg_addr_e addr, logic [31:0] data);
		@(posedge clk);
		#10;
		cfg_wr = 1'b1;
		cfg_addr = addr;
		cfg_wdata = data;
		@(posedge clk);
		#10;
		cfg_wr = 1'b0;
	endtask

	task automatic read_expect(string name, ilk_tx_pkg::ilk_reg_addr_e addr,
			logic [31:0] expected);
		@(posedge clk);
		#10;
		cfg_rd_addr = addr;
		@(posedge clk);
		check_val(name, expected, cfg_rdata);
	endtask

	// packets of one to four beats, the last one cut short at nbeats
	task automatic run_source(int n, int nbeats, int max_gap);
		ilk_tx_pkg::ilk_beat_t b;
		int left;
		int plen;
		int gap;
		left = nbeats;
		while (left > 0) begin
			plen = 1 + $urandom % 4;
			if (plen > left) begin
				plen = left;
			end
			for (int i = 0; i < plen; i++) begin
				b.num_words = 3'(1 + $urandom % ilk_tx_pkg::DAT_WORDS);
				for (int w = 0; w < ilk_tx_pkg::DAT_WORDS; w++) begin
					b.words[64*w +: 64] = {$urandom, $urandom};
				end
				b.sop = (i == 0);
				b.eopbits = (i == plen - 1) ? {1'b1, 3'($urandom % 8)} : 4'd0;
				src_beat[n] = b;
				src_vld[n] = 1'b1;
				do begin
					@(posedge clk);
				end while (!src_ready[n]);
				#10;
				left--;
			end
			gap = (max_gap > 0) ? $urandom % (max_gap + 1) : 0;
			if (gap > 0) begin
				src_vld[n] = 1'b0;
				repeat (gap) @(posedge clk);
				#10;
			end
		end
		src_vld[n] = 1'b0;
	endtask

	task automatic drain();
		while (exp_beats.size() != 0 || out_valid) begin
			@(posedge clk);
		end
		repeat (4) @(posedge clk);
	endtask

	//////////////////////////////////////////////////////////////////////
	// watchdog

	initial begin
		int total;
		total = ilk_tx_pkg::NUM_CHANS * (fair_beats + bp_beats + en_beats);
		#((total * 20 + 16) * 100);
		$display("timeout: the run did not finish in the expected number of cycles");
		$display("*** TEST FAILED ***");
		$fatal(1);
	end

	initial begin
		void'($urandom(5524));
		clk = 1'b0;
		arst = 1'b1;
		cfg_wr = 1'b0;
		cfg_addr = ilk_tx_pkg::REG_ENABLES;
		cfg_wdata = '0;
		cfg_rd_addr = ilk_tx_pkg::REG_ENABLES;
		out_ready = 1'b1;
		fair_on = 1'b0;
		bp_on = 1'b0;
		stall_prev = 1'b0;
		prev_beat = '0;
		en_model = '0;
		for (int n = 0; n < ilk_tx_pkg::NUM_CHANS; n++) begin
			src_beat[n] = '0;
			src_vld[n] = 1'b0;
			id_model[n] = 8'(n);
			cnt_model[n] = 0;
		end
		repeat (16) @(posedge clk);
		#10;
		arst = 1'b0;

		// fairness with every source busy and no back-pressure
		write_reg(ilk_tx_pkg::REG_ENABLES, 32'hf);
		fair_on = 1'b1;
		fork
			run_source(0, fair_beats, 0);
			run_source(1, fair_beats, 0);
			run_source(2, fair_beats, 0);
			run_source(3, fair_beats, 0);
		join
		drain();
		fair_on = 1'b0;

		// new identifiers, random gaps and random back-pressure
		for (int n = 0; n < ilk_tx_pkg::NUM_CHANS; n++) begin
			write_reg(ilk_tx_pkg::ilk_reg_addr_e'(n + 1), 32'h40 + n);
		end
		read_expect("chan id readback", ilk_tx_pkg::REG_CHAN_ID2, 32'h42);
		bp_on = 1'b1;
		fork
			run_source(0, bp_beats, 3);
			run_source(1, bp_beats, 3);
			run_source(2, bp_beats, 3);
			run_source(3, bp_beats, 3);
		join
		bp_on = 1'b0;
		drain();

		// channel 2 waits while disabled, then resumes once enabled again
		write_reg(ilk_tx_pkg::REG_ENABLES, 32'hb);
		fork
			run_source(0, en_beats, 2);
			run_source(1, en_beats, 2);
			run_source(2, en_beats, 2);
			run_source(3, en_beats, 2);
			begin
				repeat (60) @(posedge clk);
				write_reg(ilk_tx_pkg::REG_ENABLES, 32'hf);
			end
		join
		drain();

		read_expect("word count 0", ilk_tx_pkg::REG_CNT0, cnt_model[0]);
		read_expect("word count 1", ilk_tx_pkg::REG_CNT1, cnt_model[1]);
		read_expect("word count 2", ilk_tx_pkg::REG_CNT2, cnt_model[2]);
		read_expect("word count 3", ilk_tx_pkg::REG_CNT3, cnt_model[3]);
		write_reg(ilk_tx_pkg::REG_CNT_CLEAR, 32'h1);
		repeat (2) @(posedge clk);
		read_expect("cleared count 0", ilk_tx_pkg::REG_CNT0, 0);
		read_expect("cleared count 1", ilk_tx_pkg::REG_CNT1, 0);
		read_expect("cleared count 2", ilk_tx_pkg::REG_CNT2, 0);
		read_expect("cleared count 3", ilk_tx_pkg::REG_CNT3, 0);
		check_val("beats left over", 0, exp_beats.size());

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule
